//--- include/tcb_lite_defs.svh
// bus address and data widths
// memory depth per byte bank
`ifndef TCB_LITE_DEFS_SVH
`define TCB_LITE_DEFS_SVH

// bus byte address width
`define TCB_ADR_W 12

// bus data width, four byte lanes
`define TCB_DAT_W 32

// rows per bank, one row per bus word
`define MEM_DEPTH (1 << (`TCB_ADR_W - 2))

`endif

//--- source/tcb_lite_pkg.sv
// bus side types
// address, data, byte enable, size and offset
`include "tcb_lite_defs.svh"

package tcb_lite_pkg;

    // byte address
    typedef logic [`TCB_ADR_W-1:0] tcb_adr_t;

    // full data word
    typedef logic [`TCB_DAT_W-1:0] tcb_dat_t;

    // one enable per byte lane
    typedef logic [`TCB_DAT_W/8-1:0] tcb_byt_t;

    // logical size as log2 of byte count
    // 0 byte, 1 half-word, 2 word
    typedef logic [1:0] tcb_siz_t;

    // byte offset within a word
    typedef logic [$clog2(`TCB_DAT_W/8)-1:0] tcb_off_t;

endpackage

//--- source/sram_pkg.sv
// memory side types
// row address and lane data
`include "tcb_lite_defs.svh"

package sram_pkg;

    // row address inside one bank
    typedef logic [$clog2(`MEM_DEPTH)-1:0] mem_adr_t;

    // data of one byte lane
    typedef logic [7:0] mem_dat_t;

endpackage

//--- source/sram_byte_bank.sv
// byte wide single port SRAM bank
`timescale 1ns/10ps
`include "tcb_lite_defs.svh"

module sram_byte_bank (
    input  logic               clk,
    input  logic               arst_n,
    input  logic               cen,
    input  logic               wen,
    input  sram_pkg::mem_adr_t adr,
    input  sram_pkg::mem_dat_t wdt,
    output sram_pkg::mem_dat_t rdt
);

    import sram_pkg::*;

    // storage array, one byte per row
    mem_dat_t mem [`MEM_DEPTH];

    ////////////////////
    // write port
    ////////////////////

    // write at the edge when selected
    always_ff @(posedge clk) begin
        if (cen && wen) begin
            mem[adr] <= wdt;
        end
    end

    ////////////////////
    // read port
    ////////////////////

    // registered read data
    // holds last value while idle
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rdt <= '0;
        end else if (cen && !wen) begin
            rdt <= mem[adr];
        end
    end

endmodule

//--- source/tcb_lite_lib_misaligned_memory_controller.sv
// misaligned memory controller
// byte lanes onto per-lane SRAM banks with row advance
`timescale 1ns/10ps

module tcb_lite_lib_misaligned_memory_controller (
    // byte lane bus side
    input  logic                        vld,
    input  logic                        wen,
    input  tcb_lite_pkg::tcb_adr_t      adr,
    input  tcb_lite_pkg::tcb_byt_t      byt,
    input  tcb_lite_pkg::tcb_dat_t      wdt,
    output tcb_lite_pkg::tcb_dat_t      rdt,
    // SRAM bank side
    output logic [3:0]                  mem_cen,
    output logic                        mem_wen,
    output sram_pkg::mem_adr_t [3:0]    mem_adr,
    output sram_pkg::mem_dat_t [3:0]    mem_wdt,
    input  sram_pkg::mem_dat_t [3:0]    mem_rdt
);

    import tcb_lite_pkg::*;
    import sram_pkg::*;

    ////////////////////
    // address split
    ////////////////////

    // row of the addressed word
    mem_adr_t row;
    // following row, wraps to row 0
    mem_adr_t nxt;
    // byte offset inside the word
    tcb_off_t off;

    // low bits select the lane, rest is the row
    assign off = adr[$bits(tcb_off_t)-1:0];
    assign row = adr[$bits(tcb_off_t) +: $bits(mem_adr_t)];

    // natural overflow gives the wrap
    assign nxt = row + 1'b1;

    ////////////////////
    // bank request
    ////////////////////

    // lane enables only while a request is present
    assign mem_cen = {4{vld}} & byt;

    // one write strobe for all banks
    assign mem_wen = wen;

    // lanes below the offset hold the upper part of a wrapped access
    // so they address the next row
    for (genvar i = 0; i < 4; i++) begin : g_lane
        assign mem_adr[i] = (i < off) ? nxt : row;
    end

    // lane data already rotated by the converter
    assign mem_wdt = wdt;

    ////////////////////
    // response data
    ////////////////////

    // lane order kept, converter realigns
    assign rdt = mem_rdt;

endmodule

//--- source/tcb_lite_lib_size_to_lane_converter.sv
// logical size to byte lane converter
// request rotation and one stage read data realignment
`timescale 1ns/10ps

module tcb_lite_lib_size_to_lane_converter (
    input  logic                   clk,
    input  logic                   arst_n,
    // logical size request
    input  logic                   req_vld,
    input  logic                   req_wen,
    input  tcb_lite_pkg::tcb_adr_t req_adr,
    input  tcb_lite_pkg::tcb_siz_t req_siz,
    input  tcb_lite_pkg::tcb_dat_t req_wdt,
    // read response
    output logic                   rsp_vld,
    output tcb_lite_pkg::tcb_dat_t rsp_rdt,
    // byte lane side
    output logic                   vld,
    output logic                   wen,
    output tcb_lite_pkg::tcb_adr_t adr,
    output tcb_lite_pkg::tcb_byt_t byt,
    output tcb_lite_pkg::tcb_dat_t wdt,
    input  tcb_lite_pkg::tcb_dat_t rdt
);

    import tcb_lite_pkg::*;

    // bytes covered by a size, low aligned
    function automatic tcb_byt_t siz_msk(input tcb_siz_t siz);
        tcb_byt_t msk;
        case (siz)
            2'd0:    msk = 4'b0001;
            2'd1:    msk = 4'b0011;
            default: msk = 4'b1111;
        endcase
        return msk;
    endfunction

    ////////////////////
    // request path
    ////////////////////

    // offset of the request
    tcb_off_t req_off;
    // low aligned enables before rotation
    tcb_byt_t req_msk;

    assign req_off = req_adr[$bits(tcb_off_t)-1:0];
    assign req_msk = siz_msk(req_siz);

    // strobes and address pass straight through
    assign vld = req_vld;
    assign wen = req_wen;
    assign adr = req_adr;

    // byte k moves to lane (off + k) mod 4
    always_comb begin
        byt = '0;
        wdt = '0;
        for (int unsigned k = 0; k < 4; k++) begin
            tcb_off_t lane;
            // 2 bit sum wraps around the lanes
            lane = req_off + tcb_off_t'(k);
            byt[lane] = req_msk[k];
            wdt[8*lane +: 8] = req_wdt[8*k +: 8];
        end
    end

    ////////////////////
    // read pipeline
    ////////////////////

    // offset and size of the read in flight
    tcb_off_t rd_off;
    tcb_siz_t rd_siz;
    // enables of the read in flight
    tcb_byt_t rd_msk;

    // response valid one cycle after a read
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rsp_vld <= 1'b0;
        end else begin
            rsp_vld <= req_vld && !req_wen;
        end
    end

    // read attributes, only loaded by reads
    always_ff @(posedge clk) begin
        if (req_vld && !req_wen) begin
            rd_off <= req_off;
            rd_siz <= req_siz;
        end
    end

    assign rd_msk = siz_msk(rd_siz);

    // lane (off + k) back to byte k, zero above the size
    always_comb begin
        rsp_rdt = '0;
        for (int unsigned k = 0; k < 4; k++) begin
            tcb_off_t lane;
            lane = rd_off + tcb_off_t'(k);
            if (rd_msk[k]) begin
                rsp_rdt[8*k +: 8] = rdt[8*lane +: 8];
            end
        end
    end

endmodule

//--- source/tcb_lite_misaligned_memory.sv
// misaligned byte addressed memory, top level
// converter, controller and four byte banks
`timescale 1ns/10ps

module tcb_lite_misaligned_memory (
    input  logic                   clk,
    input  logic                   arst_n,
    // logical size request
    input  logic                   req_vld,
    input  logic                   req_wen,
    input  tcb_lite_pkg::tcb_adr_t req_adr,
    input  tcb_lite_pkg::tcb_siz_t req_siz,
    input  tcb_lite_pkg::tcb_dat_t req_wdt,
    // read response
    output logic                   rsp_vld,
    output tcb_lite_pkg::tcb_dat_t rsp_rdt
);

    import tcb_lite_pkg::*;
    import sram_pkg::*;

    ////////////////////
    // internal wires
    ////////////////////

    // byte lane bus between converter and controller
    logic     lane_vld;
    logic     lane_wen;
    tcb_adr_t lane_adr;
    tcb_byt_t lane_byt;
    tcb_dat_t lane_wdt;
    tcb_dat_t lane_rdt;

    // per bank signals
    logic [3:0]     mem_cen;
    logic           mem_wen;
    mem_adr_t [3:0] mem_adr;
    mem_dat_t [3:0] mem_wdt;
    mem_dat_t [3:0] mem_rdt;

    ////////////////////
    // size to lanes
    ////////////////////

    tcb_lite_lib_size_to_lane_converter u_converter (
        .clk     (clk),
        .arst_n  (arst_n),
        .req_vld (req_vld),
        .req_wen (req_wen),
        .req_adr (req_adr),
        .req_siz (req_siz),
        .req_wdt (req_wdt),
        .rsp_vld (rsp_vld),
        .rsp_rdt (rsp_rdt),
        .vld     (lane_vld),
        .wen     (lane_wen),
        .adr     (lane_adr),
        .byt     (lane_byt),
        .wdt     (lane_wdt),
        .rdt     (lane_rdt)
    );

    ////////////////////
    // lanes to banks
    ////////////////////

    tcb_lite_lib_misaligned_memory_controller u_controller (
        .vld     (lane_vld),
        .wen     (lane_wen),
        .adr     (lane_adr),
        .byt     (lane_byt),
        .wdt     (lane_wdt),
        .rdt     (lane_rdt),
        .mem_cen (mem_cen),
        .mem_wen (mem_wen),
        .mem_adr (mem_adr),
        .mem_wdt (mem_wdt),
        .mem_rdt (mem_rdt)
    );

    // one bank per byte lane
    for (genvar i = 0; i < 4; i++) begin : g_bank
        sram_byte_bank u_bank (
            .clk    (clk),
            .arst_n (arst_n),
            .cen    (mem_cen[i]),
            .wen    (mem_wen),
            .adr    (mem_adr[i]),
            .wdt    (mem_wdt[i]),
            .rdt    (mem_rdt[i])
        );
    end

endmodule

//--- verification/tb_clock_gen.sv
// testbench clock and reset source
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int unsigned PERIOD_NS    = 20,
    parameter int unsigned RESET_CYCLES = 3
) (
    output logic clk,
    output logic arst_n
);

    // free running clock
    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // reset low for a fixed number of rising edges
    // released just after the edge
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        arst_n = 1'b1;
    end

endmodule

//--- verification/tcb_lite_misaligned_memory_assertions.sv
// concurrent assertions for the misaligned memory top level
// response latency, lane enable gating, wrapped row address
`timescale 1ns/10ps

module tcb_lite_misaligned_memory_assertions (
    input logic                     clk,
    input logic                     arst_n,
    input logic                     req_vld,
    input logic                     req_wen,
    input tcb_lite_pkg::tcb_adr_t   req_adr,
    input logic                     rsp_vld,
    input logic [3:0]               mem_cen,
    input sram_pkg::mem_adr_t [3:0] mem_adr
);

    import tcb_lite_pkg::*;
    import sram_pkg::*;

    // offset and row of the request on the bus
    tcb_off_t off;
    mem_adr_t row;

    assign off = req_adr[$bits(tcb_off_t)-1:0];
    assign row = req_adr[$bits(tcb_off_t) +: $bits(mem_adr_t)];

    ////////////////////
    // response timing
    ////////////////////

    // a read is answered on the next edge
    rd_rsp: assert property (@(posedge clk) disable iff (!arst_n)
        (req_vld && !req_wen) |=> rsp_vld)
        else $error("read request without response one cycle later");

    // and nothing else produces a response
    no_rsp: assert property (@(posedge clk) disable iff (!arst_n)
        !(req_vld && !req_wen) |=> !rsp_vld)
        else $error("response without a read request one cycle earlier");

    ////////////////////
    // bank side
    ////////////////////

    // banks stay quiet without a request
    cen_idle: assert property (@(posedge clk) disable iff (!arst_n)
        !req_vld |-> (mem_cen == 4'b0000))
        else $error("bank enabled while no request is present");

    // lanes below the offset use the next row including the wrap
    // lane 3 is never below the offset
    for (genvar i = 0; i < 3; i++) begin : g_wrap
        wrap_row: assert property (@(posedge clk) disable iff (!arst_n)
            (req_vld && (i < off)) |-> (mem_adr[i] == mem_adr_t'(row + 1'b1)))
            else $error("lane %0d did not address the next row", i);
    end

endmodule

bind tcb_lite_misaligned_memory tcb_lite_misaligned_memory_assertions u_assertions (
    .clk     (clk),
    .arst_n  (arst_n),
    .req_vld (req_vld),
    .req_wen (req_wen),
    .req_adr (req_adr),
    .rsp_vld (rsp_vld),
    .mem_cen (mem_cen),
    .mem_adr (mem_adr)
);

//--- verification/tcb_lite_misaligned_memory_tb.sv
// testbench for the misaligned byte addressed memory
// byte array reference model, response checker, final report
`timescale 1ns/10ps
`include "tcb_lite_defs.svh"

module tcb_lite_misaligned_memory_tb;

    import tcb_lite_pkg::*;

    localparam int unsigned MEM_BYTES = 1 << `TCB_ADR_W;
    // longest any single wait may take, in cycles
    localparam int unsigned WAIT_MAX  = 20;
    localparam int unsigned BURST_LEN = 300;
    // accesses around row boundaries, last ones wrap to row 0
    localparam tcb_adr_t EDGE_ADR [7] = '{12'h203, 12'h206, 12'h209, 12'h3ff,
                                          12'hffd, 12'hffe, 12'hfff};

    logic     clk;
    logic     arst_n;
    logic     req_vld;
    logic     req_wen;
    tcb_adr_t req_adr;
    tcb_siz_t req_siz;
    tcb_dat_t req_wdt;
    logic     rsp_vld;
    tcb_dat_t rsp_rdt;

    // one entry per byte address
    logic [7:0]  ref_mem [MEM_BYTES];
    // expected read data and issue cycle, oldest first
    tcb_dat_t    exp_q [$];
    int unsigned cyc_q [$];

    int unsigned cycle = 0;
    int unsigned errors;
    int unsigned checks;
    integer      seed;

    tb_clock_gen u_clock_gen (
        .clk    (clk),
        .arst_n (arst_n)
    );

    tcb_lite_misaligned_memory u_dut (
        .clk     (clk),
        .arst_n  (arst_n),
        .req_vld (req_vld),
        .req_wen (req_wen),
        .req_adr (req_adr),
        .req_siz (req_siz),
        .req_wdt (req_wdt),
        .rsp_vld (rsp_vld),
        .rsp_rdt (rsp_rdt)
    );

    always @(posedge clk) cycle <= cycle + 1;

    ////////////////////
    // reference model
    ////////////////////

    // initial byte value, every address bit matters
    function automatic logic [7:0] fill_byte(input tcb_adr_t a);
        return a[7:0] ^ {a[11:8], 4'ha};
    endfunction

    // bytes at adr upward, wrapping at the top, zero above the size
    function automatic tcb_dat_t ref_read(input tcb_adr_t adr, input tcb_siz_t siz);
        tcb_dat_t    dat;
        int unsigned nbyt;
        dat  = '0;
        nbyt = 1 << siz;
        for (int unsigned k = 0; k < nbyt; k++) begin
            dat[8*k +: 8] = ref_mem[(adr + k) % MEM_BYTES];
        end
        return dat;
    endfunction

    task automatic compare_value(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL t=%0t %s: got %h expected %h", $time, name, got, exp);
        end
    endtask

    ////////////////////
    // drivers
    ////////////////////

    task automatic send_write(input tcb_adr_t adr, input tcb_siz_t siz, input tcb_dat_t dat);
        int unsigned nbyt;
        nbyt = 1 << siz;
        @(posedge clk);
        #2;
        req_vld = 1'b1;
        req_wen = 1'b1;
        req_adr = adr;
        req_siz = siz;
        req_wdt = dat;
        // bytes above the size are left in req_wdt on purpose
        for (int unsigned k = 0; k < nbyt; k++) begin
            ref_mem[(adr + k) % MEM_BYTES] = dat[8*k +: 8];
        end
    endtask

    task automatic send_read(input tcb_adr_t adr, input tcb_siz_t siz);
        @(posedge clk);
        #2;
        req_vld = 1'b1;
        req_wen = 1'b0;
        req_adr = adr;
        req_siz = siz;
        req_wdt = $random(seed);
        exp_q.push_back(ref_read(adr, siz));
        cyc_q.push_back(cycle);
    endtask

    task automatic send_idle();
        @(posedge clk);
        #2;
        req_vld = 1'b0;
        req_wen = 1'b0;
    endtask

    task automatic send_random();
        tcb_adr_t adr;
        tcb_siz_t siz;
        tcb_dat_t dat;
        logic     wr;
        adr = tcb_adr_t'($random(seed));
        siz = tcb_siz_t'($unsigned($random(seed)) % 3);
        dat = $random(seed);
        wr  = $random(seed) & 1;
        if (wr) begin
            send_write(adr, siz, dat);
        end else begin
            send_read(adr, siz);
        end
    endtask

    ////////////////////
    // response checker
    ////////////////////

    // outputs are settled at the falling edge
    always @(negedge clk) begin
        if (arst_n && rsp_vld) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("ERROR: read response at %0t with no read outstanding", $time);
            end else begin
                compare_value("rsp_rdt", rsp_rdt, exp_q.pop_front());
                compare_value("rsp_vld cycle", cycle, cyc_q.pop_front() + 1);
            end
        end
    end

    ////////////////////
    // test sequence
    ////////////////////

    initial begin
        int unsigned n;
        tcb_adr_t    a;
        tcb_dat_t    w;
        seed    = 32'h38f3;
        errors  = 0;
        checks  = 0;
        req_vld = 1'b0;
        req_wen = 1'b0;
        req_adr = '0;
        req_siz = '0;
        req_wdt = '0;

        n = 0;
        while (arst_n !== 1'b1 && n < WAIT_MAX) begin
            @(posedge clk);
            n++;
        end
        if (arst_n !== 1'b1) begin
            errors++;
            $display("ERROR: reset was not released within %0d cycles", WAIT_MAX);
        end
        compare_value("rsp_vld", rsp_vld, 32'd0);

        // fill with aligned word writes, no response expected
        for (int unsigned r = 0; r < MEM_BYTES / 4; r++) begin
            a = tcb_adr_t'(4 * r);
            for (int unsigned k = 0; k < 4; k++) begin
                w[8*k +: 8] = fill_byte(tcb_adr_t'(a + k));
            end
            send_write(a, 2'd2, w);
        end

        // aligned words, write then read
        for (int unsigned i = 0; i < 16; i++) begin
            a = tcb_adr_t'($random(seed)) & ~tcb_adr_t'(3);
            send_write(a, 2'd2, $random(seed));
            send_read(a, 2'd2);
        end
        for (int unsigned i = 0; i < 8; i++) begin
            send_read(tcb_adr_t'(12'h400 + 4 * i), 2'd2);
        end

        // bytes and half-words at every offset
        for (int unsigned off = 0; off < 4; off++) begin
            send_write(tcb_adr_t'(12'h100 + off), 2'd0, $random(seed));
            send_read(12'h100, 2'd2);
        end
        for (int unsigned off = 0; off < 4; off++) begin
            a = tcb_adr_t'(12'h140 + 9 * off);
            send_write(a, 2'd1, $random(seed));
            send_read(a & ~tcb_adr_t'(3), 2'd2);
            send_read(tcb_adr_t'((a & ~tcb_adr_t'(3)) + 4), 2'd2);
        end

        // row crossing and top of memory wrap
        for (int unsigned i = 0; i < 7; i++) begin
            a = EDGE_ADR[i];
            send_write(a, 2'd2, $random(seed));
            send_read(a, 2'd2);
            send_write(tcb_adr_t'(a + 1), 2'd1, $random(seed));
            send_read(a, 2'd2);
            send_read(tcb_adr_t'(a + 2), 2'd1);
        end

        // back to back random traffic
        for (int unsigned i = 0; i < BURST_LEN; i++) begin
            send_random();
        end
        send_idle();

        n = 0;
        while (exp_q.size() != 0 && n < WAIT_MAX) begin
            @(posedge clk);
            n++;
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("ERROR: %0d read responses still missing after %0d cycles",
                     exp_q.size(), WAIT_MAX);
        end
        send_idle();
        send_idle();

        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

//--- tcb_lite_misaligned_memory.f
+incdir+include
source/tcb_lite_pkg.sv
source/sram_pkg.sv
source/sram_byte_bank.sv
source/tcb_lite_lib_misaligned_memory_controller.sv
source/tcb_lite_lib_size_to_lane_converter.sv
source/tcb_lite_misaligned_memory.sv
verification/tb_clock_gen.sv
verification/tcb_lite_misaligned_memory_assertions.sv
verification/tcb_lite_misaligned_memory_tb.sv

//--- Makefile
# Verilator build and run for the misaligned memory testbench

VERILATOR ?= verilator
TOP       ?= tcb_lite_misaligned_memory_tb
FILELIST  ?= tcb_lite_misaligned_memory.f
BUILD_DIR ?= build
LOG       ?= $(BUILD_DIR)/sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal

PASS_MSG = Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, search the log for the pass line"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o sim
	-$(BUILD_DIR)/sim > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR)
